/* rtl/frame_consts.svh */
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// element width in bits
`define FRAME_IN_WIDTH 8
// elements per input beat
`define FRAME_IN_SIZE 8
// elements per frame, also the RAM depth
`define FRAME_ADDR_RANGE 100
`define FRAME_ADDR_WIDTH 7
// wide enough for a full frame of 255s
`define FRAME_SUM_WIDTH 16

`endif

/* rtl/frame_stream_pkg.sv */
`include "frame_consts.svh"

package frame_stream_pkg;

  // one unsigned element
  typedef logic [`FRAME_IN_WIDTH-1:0] elem_t;

  // element 0 sits in the low bits and is written first
  typedef elem_t [`FRAME_IN_SIZE-1:0] beat_t;

  // reduction result of one frame
  typedef struct packed {
    logic [7:0]                  seq;
    elem_t                       max;
    logic [`FRAME_SUM_WIDTH-1:0] sum;
  } frame_result_t;

endpackage

/* rtl/frame_mem_pkg.sv */
`include "frame_consts.svh"

package frame_mem_pkg;

  typedef logic [`FRAME_ADDR_WIDTH-1:0] mem_addr_t;

  // write command towards port 1 of the frame RAM
  typedef struct packed {
    logic                       en;
    mem_addr_t                  addr;
    logic [`FRAME_IN_WIDTH-1:0] data;
  } mem_wr_t;

  // read request towards port 0
  typedef struct packed {
    logic      ce;
    mem_addr_t addr;
  } mem_rd_req_t;

endpackage

/* rtl/ram_block.sv */
`timescale 1ns/10ps

module ram_block #(
  parameter int DWIDTH   = 8,
  parameter int AWIDTH   = 7,
  parameter int MEM_SIZE = 100
) (
  input  logic              clk,
  input  logic [AWIDTH-1:0] addr1,
  input  logic              ce1,
  input  logic              we1,
  input  logic [DWIDTH-1:0] d1,
  output logic [DWIDTH-1:0] q1,
  input  logic [AWIDTH-1:0] addr0,
  input  logic              ce0,
  output logic [DWIDTH-1:0] q0
);

  logic [DWIDTH-1:0] mem [MEM_SIZE];

  // port 1 writes; without we1 it returns the stored word
  always_ff @(posedge clk) begin
    if (ce1) begin
      if (we1) begin
        mem[addr1] <= d1;
      end else begin
        q1 <= mem[addr1];
      end
    end
  end

  // port 0 registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    if (ce0) begin
      q0 <= mem[addr0];
    end
  end

endmodule

/* rtl/hs2bram_cast.sv */
`timescale 1ns/10ps
`include "frame_consts.svh"

module hs2bram_cast (
  input  logic                        clk,
  input  logic                        rst,
  input  frame_stream_pkg::beat_t     in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  frame_mem_pkg::mem_rd_req_t  rd_req,
  output frame_stream_pkg::elem_t     rd_data,
  output logic                        frame_start,
  input  logic                        frame_ready
);

  import frame_stream_pkg::*;
  import frame_mem_pkg::*;

  localparam int unsigned CNT_W = $clog2(`FRAME_IN_SIZE);
  localparam logic [CNT_W-1:0] LAST_ELEM = CNT_W'(`FRAME_IN_SIZE - 1);
  localparam mem_addr_t LAST_ADDR = mem_addr_t'(`FRAME_ADDR_RANGE - 1);

  // idle waits for a beat, write unpacks it, full holds a frame for the reducer
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_FULL
  } cast_state_t;

  cast_state_t      state;
  beat_t            beat_buf;
  logic [CNT_W-1:0] elem_cnt;
  mem_addr_t        addr_cnt;
  mem_wr_t          wr;

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && in_valid) begin
      beat_buf <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      elem_cnt <= '0;
    end else if (state == ST_IDLE && in_valid) begin
      elem_cnt <= '0;
    end else if (state == ST_WRITE) begin
      elem_cnt <= elem_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_cnt <= '0;
    end else if (state == ST_FULL) begin
      addr_cnt <= '0;
    end else if (state == ST_WRITE) begin
      addr_cnt <= addr_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (in_valid) begin
            state <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          // a full frame wins, the rest of the beat is dropped
          if (addr_cnt == LAST_ADDR) begin
            state <= ST_FULL;
          end else if (elem_cnt == LAST_ELEM) begin
            state <= ST_IDLE;
          end
        end
        ST_FULL: begin
          // frame_ready comes with the reducer's last read
          if (frame_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign wr.en   = (state == ST_WRITE);
  assign wr.addr = addr_cnt;
  assign wr.data = beat_buf[elem_cnt];

  assign in_ready    = (state == ST_IDLE);
  assign frame_start = (state == ST_FULL);

  ram_block #(
    .DWIDTH   (`FRAME_IN_WIDTH),
    .AWIDTH   (`FRAME_ADDR_WIDTH),
    .MEM_SIZE (`FRAME_ADDR_RANGE)
  ) data_ram (
    .clk   (clk),
    .addr1 (wr.addr),
    .ce1   (wr.en),
    .we1   (wr.en),
    .d1    (wr.data),
    .q1    (),
    .addr0 (rd_req.addr),
    .ce0   (rd_req.ce),
    .q0    (rd_data)
  );

endmodule

/* rtl/frame_reducer.sv */
`timescale 1ns/10ps
`include "frame_consts.svh"

module frame_reducer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            frame_start,
  output logic                            frame_ready,
  output frame_mem_pkg::mem_rd_req_t      rd_req,
  input  frame_stream_pkg::elem_t         rd_data,
  output frame_stream_pkg::frame_result_t res,
  output logic                            res_valid,
  input  logic                            res_ready
);

  import frame_stream_pkg::*;
  import frame_mem_pkg::*;

  localparam mem_addr_t LAST_ADDR = mem_addr_t'(`FRAME_ADDR_RANGE - 1);

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_READ,
    RS_DRAIN,
    RS_HOLD
  } red_state_t;

  red_state_t                  state;
  mem_addr_t                   rd_addr;
  logic                        rd_active;
  logic                        rd_last;
  logic                        data_vld;
  logic [`FRAME_SUM_WIDTH-1:0] sum_acc;
  elem_t                       max_acc;
  logic [7:0]                  seq_cnt;

  // the first read goes out in the cycle frame_start is seen
  assign rd_active = (state == RS_IDLE && frame_start) || (state == RS_READ);
  assign rd_last   = rd_active && (rd_addr == LAST_ADDR);

  // address returns to zero in every cycle without a read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (!rd_active) begin
      rd_addr <= '0;
    end else begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // RAM data comes back one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      data_vld <= 1'b0;
    end else begin
      data_vld <= rd_active;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RS_IDLE;
    end else begin
      case (state)
        RS_IDLE: begin
          if (rd_last) begin
            state <= RS_DRAIN;
          end else if (frame_start) begin
            state <= RS_READ;
          end
        end
        RS_READ: begin
          if (rd_last) begin
            state <= RS_DRAIN;
          end
        end
        // last element is accumulated here
        RS_DRAIN: state <= RS_HOLD;
        RS_HOLD: begin
          if (res_ready) begin
            state <= RS_IDLE;
          end
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

  // accumulators sit at zero between frames
  always_ff @(posedge clk) begin
    if (state == RS_IDLE) begin
      sum_acc <= '0;
      max_acc <= '0;
    end else if (data_vld) begin
      sum_acc <= sum_acc + `FRAME_SUM_WIDTH'(rd_data);
      if (rd_data > max_acc) begin
        max_acc <= rd_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (res_valid && res_ready) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  assign rd_req.ce   = rd_active;
  assign rd_req.addr = rd_addr;
  assign frame_ready = rd_last;

  assign res_valid = (state == RS_HOLD);
  assign res.seq   = seq_cnt;
  assign res.max   = max_acc;
  assign res.sum   = sum_acc;

endmodule

/* rtl/frame_sum_top.sv */
`timescale 1ns/10ps

module frame_sum_top (
  input  logic                            clk,
  input  logic                            rst,
  input  frame_stream_pkg::beat_t         in_beat,
  input  logic                            in_valid,
  output logic                            in_ready,
  output frame_stream_pkg::frame_result_t res,
  output logic                            res_valid,
  input  logic                            res_ready
);

  import frame_stream_pkg::*;
  import frame_mem_pkg::*;

  // frame hand-off between cast and reducer
  logic        frame_start;
  logic        frame_ready;
  mem_rd_req_t rd_req;
  elem_t       rd_data;

  hs2bram_cast u_cast (
    .clk         (clk),
    .rst         (rst),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .frame_start (frame_start),
    .frame_ready (frame_ready)
  );

  frame_reducer u_reducer (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .frame_ready (frame_ready),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .res         (res),
    .res_valid   (res_valid),
    .res_ready   (res_ready)
  );

endmodule

/* sim/frame_sum_asserts.sv */
`timescale 1ns/10ps

module frame_sum_asserts (
  input logic                            clk,
  input logic                            rst,
  input logic                            in_ready,
  input frame_mem_pkg::mem_rd_req_t      rd_req,
  input frame_stream_pkg::frame_result_t res,
  input logic                            res_valid,
  input logic                            res_ready
);

  int assert_errors = 0;

  // a waiting result keeps its value and its valid
  res_hold: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else begin
      assert_errors++;
      $error("result changed while it waited for res_ready");
    end

  // the intake stays closed while the reducer reads the held frame
  intake_closed: assert property (@(posedge clk) disable iff (rst)
    rd_req.ce |-> !in_ready)
    else begin
      assert_errors++;
      $error("in_ready high while the reducer reads the frame");
    end

  reset_quiet: assert property (@(posedge clk) rst |=> !res_valid)
    else begin
      assert_errors++;
      $error("res_valid high right after reset");
    end

endmodule

/* sim/tb_frame_sum.sv */
`timescale 1ns/10ps
`include "frame_consts.svh"

module tb_frame_sum;

  import frame_stream_pkg::*;

  localparam int NUM_FRAMES = 12;
  // 300 cycles per frame leaves room for random stalls on both ports
  localparam int WATCHDOG_NS = (NUM_FRAMES * 300 + 20) * 10;

  logic          clk = 1'b0;
  logic          rst;
  beat_t         in_beat;
  logic          in_valid;
  logic          in_ready;
  frame_result_t res;
  logic          res_valid;
  logic          res_ready;

  integer        seed = 32'hd0bf_4010;
  int            err_count = 0;
  int            results_seen = 0;
  int            frames_done = 0;
  int            accepted_beats = 0;
  int            stall_left = 0;
  logic [7:0]    next_seq = '0;
  logic          in_fire = 1'b0;
  logic          res_fire = 1'b0;
  elem_t         frame_elems[$];
  frame_result_t exp_q[$];

  frame_sum_top uut (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  bind frame_sum_top frame_sum_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .rd_req    (rd_req),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  always #5 clk = ~clk;

  task automatic check_result(input frame_result_t got, input frame_result_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t: result seq %0d sum %0d max %0d, expected seq %0d sum %0d max %0d",
               $time, got.seq, got.sum, got.max, exp.seq, exp.sum, exp.max);
    end
  endtask

  task automatic close_frame();
    frame_result_t exp;
    int            sum;
    elem_t         mx;
    sum = 0;
    mx  = '0;
    foreach (frame_elems[i]) begin
      sum += frame_elems[i];
      if (frame_elems[i] > mx) begin
        mx = frame_elems[i];
      end
    end
    exp.seq = next_seq;
    exp.max = mx;
    exp.sum = `FRAME_SUM_WIDTH'(sum);
    exp_q.push_back(exp);
    next_seq++;
    frames_done++;
    frame_elems.delete();
  endtask

  task automatic accept_beat(input beat_t b);
    int   k;
    logic done;
    done = 1'b0;
    accepted_beats++;
    for (k = 0; k < `FRAME_IN_SIZE; k++) begin
      if (!done) begin
        frame_elems.push_back(b[k]);
        // elements past the frame end go nowhere
        if (frame_elems.size() == `FRAME_ADDR_RANGE) begin
          close_frame();
          done = 1'b1;
        end
      end
    end
  endtask

  task automatic take_result(input frame_result_t got);
    if (exp_q.size() == 0) begin
      err_count++;
      $display("a result came out at %0t although no frame was complete", $time);
    end else begin
      check_result(got, exp_q.pop_front());
    end
    results_seen++;
  endtask

  // a waiting result stalls the reducer, so a second finished frame keeps the cast busy
  task automatic check_hold();
    if (res_valid && !res_ready && exp_q.size() >= 2 && in_ready) begin
      err_count++;
      $display("FAIL %0t: in_ready high while a full frame waits behind a result", $time);
    end
  endtask

  // frames rotate through wide, small and 255-heavy data
  task automatic make_beat(output beat_t b);
    int k;
    for (k = 0; k < `FRAME_IN_SIZE; k++) begin
      case (frames_done % 3)
        0: b[k] = elem_t'($random(seed));
        1: b[k] = elem_t'($random(seed) & 32'h1f);
        default: b[k] = (($random(seed) & 7) == 0) ? 8'hff : elem_t'($random(seed));
      endcase
    end
  endtask

  task automatic drive_next();
    int pct;
    // a beat stays on the bus until it is taken
    if (!in_valid || in_fire) begin
      pct = $unsigned($random(seed)) % 100;
      in_valid = (pct < 70);
      if (in_valid) begin
        make_beat(in_beat);
      end
    end
    pct = $unsigned($random(seed)) % 100;
    res_ready = (pct < 60);
    // every fourth result waits until the next frame is complete and held in the cast
    if (results_seen % 4 == 1) begin
      if (exp_q.size() < 2) begin
        stall_left = 20;
      end
      if (stall_left > 0) begin
        stall_left--;
        res_ready = 1'b0;
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    res_ready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    wait (results_seen == NUM_FRAMES);
    repeat (2) @(posedge clk);
    $display("errors: %0d checks, %0d assertions (%0d beats, %0d results)",
             err_count, uut.u_asserts.assert_errors, accepted_beats, results_seen);
    if (err_count + uut.u_asserts.assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // handshakes are sampled at the falling edge where both sides are stable
  initial begin
    wait (rst === 1'b0);
    forever begin
      @(negedge clk);
      check_hold();
      in_fire  = in_valid && in_ready;
      res_fire = res_valid && res_ready;
      if (in_fire) begin
        accept_beat(in_beat);
      end
      if (res_fire) begin
        take_result(res);
      end
      @(posedge clk);
      #1;
      drive_next();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d results arrived within %0d ns",
             results_seen, NUM_FRAMES, WATCHDOG_NS);
    $display("errors: %0d checks, %0d assertions", err_count, uut.u_asserts.assert_errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* frame_sum.f */
+incdir+rtl
rtl/frame_stream_pkg.sv
rtl/frame_mem_pkg.sv
rtl/ram_block.sv
rtl/hs2bram_cast.sv
rtl/frame_reducer.sv
rtl/frame_sum_top.sv
sim/frame_sum_asserts.sv
sim/tb_frame_sum.sv
